// File: src/skirocCtrl_macros.svh
// Widths, command opcodes, power-on reset length and shift-clock timing
`ifndef SKIROC_CTRL_MACROS_SVH
`define SKIROC_CTRL_MACROS_SVH

//////////////////////////////
// Host command word
`define CMD_W        16      // Whole command
`define OPC_W        4       // Opcode in the top bits
`define PAY_W        12      // Payload in the low bits

// Opcode values
`define OPC_GAIN_DAC  4'd1
`define OPC_TRIG_DAC  4'd2
`define OPC_ANALOG    4'd3
`define OPC_MODE      4'd4
`define OPC_START_CFG 4'd5
`define OPC_PROBE_CH  4'd6
`define OPC_POWER     4'd7

//////////////////////////////
// Slow control fields
`define DAC_W        10      // Threshold DAC code
`define CAP_W        4       // Feedback cap select
`define CH_W         6       // Probe channel index
`define CHIP_ID      8'h01   // Trails the config frame
`define SC_BITS      34      // 10+10+4+1+1+8
`define PROBE_BITS   64      // One bit per channel
`define SR_HALF      2       // Clk cycles per shift clock half period

// Reset and readout
`define POR_CYCLES   16      // Internal reset length after load
`define WORD_W       16      // Readout word

`endif

// File: src/skirocCtrlPkg.sv
// Vector typedefs, slow-control config struct, opcode enum and serializer state enum
`include "skirocCtrl_macros.svh"

package skirocCtrlPkg;

  //////////////////////////////
  // Plain vectors with a meaning
  typedef logic [`CMD_W-1:0]  cmdWord_t;   // Host command word
  typedef logic [`DAC_W-1:0]  dacCode_t;   // Gain or trigger threshold
  typedef logic [`CAP_W-1:0]  capSel_t;    // Preamp feedback capacitance
  typedef logic [`CH_W-1:0]   chanIdx_t;   // Probe channel
  typedef logic [`WORD_W-1:0] roWord_t;    // Readout word to host

  // Command opcodes, top nibble of the word
  typedef enum logic [`OPC_W-1:0] {
    OP_GAIN_DAC  = `OPC_GAIN_DAC,
    OP_TRIG_DAC  = `OPC_TRIG_DAC,
    OP_ANALOG    = `OPC_ANALOG,
    OP_MODE      = `OPC_MODE,
    OP_START_CFG = `OPC_START_CFG,
    OP_PROBE_CH  = `OPC_PROBE_CH,
    OP_POWER     = `OPC_POWER
  } opcode_t;

  //////////////////////////////
  // Slow control settings held by the decoder
  typedef struct packed {
    dacCode_t gainDac;      // First in the config frame
    dacCode_t trigDac;
    capSel_t  feedbackCap;
    logic     workMode;     // Normal or calibration
    logic     tdcOn;
    chanIdx_t probeChan;    // Only used by the probe frame
    logic     selectSc;     // 1 config frame, 0 probe frame
  } scConfig_t;

  // Shift clock phases
  typedef enum logic [1:0] {
    IDLE,
    LOW,
    HIGH
  } shiftState_t;

endpackage

// File: src/powerOnReset.sv
// Power-on reset stretcher with a two-stage reset input synchronizer
`timescale 1ns/1ps
`include "skirocCtrl_macros.svh"

module powerOnReset (
  input  logic Clk_Out_2_All,
  input  logic reset_i,
  output logic rstInt_o
);

  localparam int unsigned POR_W = $clog2(`POR_CYCLES + 1);

  logic [POR_W-1:0] porCnt = '0;   // Starts from zero at configuration
  logic             porBusy;
  logic             rstMeta;
  logic             rstSync;

  // Still inside the power-on window
  assign porBusy = (porCnt < POR_W'(`POR_CYCLES));

  // Counts once, then saturates
  always @(posedge Clk_Out_2_All)
  begin
    if (porBusy)
    begin
      porCnt <= porCnt + 1'b1;
    end
  end

  // Two flops on the external reset
  always_ff @(posedge Clk_Out_2_All)
  begin
    rstMeta <= reset_i;
    rstSync <= rstMeta;    // reset_i two cycles late
  end

  assign rstInt_o = porBusy || rstSync;

endmodule

// File: src/commandDecoder.sv
// Host command decoder driving slow control settings, power level and start pulse
`timescale 1ns/1ps
`include "skirocCtrl_macros.svh"

module commandDecoder (
  input  logic                     Clk_Out_2_All,
  input  logic                     reset_i,
  input  skirocCtrlPkg::cmdWord_t  cmdData_i,
  input  logic                     cmdValid_i,
  output skirocCtrlPkg::scConfig_t config_o,
  output logic                     startCfg_o,
  output logic                     powerOn_o
);

  import skirocCtrlPkg::*;

  opcode_t           opcode;
  logic [`PAY_W-1:0] payload;

  //////////////////////////////
  // Field split
  assign opcode  = opcode_t'(cmdData_i[`CMD_W-1 -: `OPC_W]);   // Top nibble
  assign payload = cmdData_i[`PAY_W-1:0];

  //////////////////////////////
  // Register update, one cycle after the strobe
  always_ff @(posedge Clk_Out_2_All)
  begin
    if (reset_i)
    begin
      config_o   <= '0;      // All fields cleared
      startCfg_o <= 1'b0;
      powerOn_o  <= 1'b0;    // Front end powered down
    end
    else
    begin
      startCfg_o <= 1'b0;    // Single cycle only
      if (cmdValid_i)
      begin
        case (opcode)
          OP_GAIN_DAC:
          begin
            config_o.gainDac <= payload[`DAC_W-1:0];
          end
          OP_TRIG_DAC:
          begin
            config_o.trigDac <= payload[`DAC_W-1:0];
          end
          OP_ANALOG:
          begin
            // Three analog settings share one word
            config_o.feedbackCap <= payload[`CAP_W-1:0];
            config_o.workMode    <= payload[4];
            config_o.tdcOn       <= payload[5];
          end
          OP_MODE:
          begin
            config_o.selectSc <= payload[0];    // Frame choice and select pin
          end
          OP_START_CFG:
          begin
            startCfg_o <= 1'b1;
          end
          OP_PROBE_CH:
          begin
            config_o.probeChan <= payload[`CH_W-1:0];
          end
          OP_POWER:
          begin
            powerOn_o <= payload[0];    // Power pulsing level
          end
          default:
          begin
            // Unknown opcode, no effect
          end
        endcase
      end
    end
  end

  // Host never sends two start words on consecutive cycles
  startSinglePulseA: assert property (@(posedge Clk_Out_2_All) disable iff (reset_i)
    startCfg_o |=> !startCfg_o)
    else $error("startCfg_o high on two consecutive cycles");

endmodule

// File: src/slowControlSerializer.sv
// Slow control and probe register serializer with its own shift clock
`timescale 1ns/1ps
`include "skirocCtrl_macros.svh"

module slowControlSerializer (
  input  logic                     Clk_Out_2_All,
  input  logic                     reset_i,
  input  skirocCtrlPkg::scConfig_t config_i,
  input  logic                     startCfg_i,
  output logic                     srCk_o,
  output logic                     srIn_o,
  output logic                     cfgDone_o
);

  import skirocCtrlPkg::*;

  localparam int unsigned FRAME_W = `PROBE_BITS;                // Widest frame
  localparam int unsigned CNT_W   = $clog2(`PROBE_BITS + 1);
  localparam int unsigned HALF_W  = $clog2(`SR_HALF + 1);

  shiftState_t        state;
  logic [FRAME_W-1:0] shiftReg;   // MSB is on the pin
  logic [FRAME_W-1:0] probeFrame;
  logic [FRAME_W-1:0] frameSel;
  logic [`SC_BITS-1:0] cfgFrame;
  logic [CNT_W-1:0]   bitsLeft;
  logic [HALF_W-1:0]  halfCnt;
  logic               halfEnd;

  //////////////////////////////
  // Frame build
  // Config order, MSB first
  assign cfgFrame = {config_i.gainDac, config_i.trigDac, config_i.feedbackCap,
                     config_i.workMode, config_i.tdcOn, `CHIP_ID};

  // One-hot over the channels
  always_comb
  begin
    probeFrame = '0;
    probeFrame[config_i.probeChan] = 1'b1;
  end

  // Config frame left aligned, zero filled
  assign frameSel = config_i.selectSc ? {cfgFrame, {(FRAME_W - `SC_BITS){1'b0}}}
                                      : probeFrame;

  assign halfEnd = (halfCnt == HALF_W'(`SR_HALF - 1));   // Last cycle of a phase
  assign srIn_o  = shiftReg[FRAME_W-1];

  //////////////////////////////
  // Shift FSM
  always_ff @(posedge Clk_Out_2_All)
  begin
    if (reset_i)
    begin
      state     <= IDLE;
      shiftReg  <= '0;     // Data pin low
      bitsLeft  <= '0;
      halfCnt   <= '0;
      srCk_o    <= 1'b0;
      cfgDone_o <= 1'b0;
    end
    else
    begin
      cfgDone_o <= 1'b0;
      case (state)
        IDLE:
        begin
          // Start while busy falls through here unseen
          if (startCfg_i)
          begin
            shiftReg <= frameSel;    // Frame frozen for the whole shift
            bitsLeft <= config_i.selectSc ? CNT_W'(`SC_BITS) : CNT_W'(`PROBE_BITS);
            halfCnt  <= '0;
            state    <= LOW;
          end
        end
        LOW:
        begin
          if (halfEnd)
          begin
            halfCnt <= '0;
            srCk_o  <= 1'b1;         // Rising edge, data already settled
            state   <= HIGH;
          end
          else
          begin
            halfCnt <= halfCnt + 1'b1;
          end
        end
        HIGH:
        begin
          if (halfEnd)
          begin
            halfCnt  <= '0;
            srCk_o   <= 1'b0;
            shiftReg <= {shiftReg[FRAME_W-2:0], 1'b0};   // Next bit with falling edge
            bitsLeft <= bitsLeft - 1'b1;
            if (bitsLeft == CNT_W'(1))
            begin
              cfgDone_o <= 1'b1;     // Whole frame sent
              state     <= IDLE;
            end
            else
            begin
              state <= LOW;
            end
          end
          else
          begin
            halfCnt <= halfCnt + 1'b1;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Checks
  // Chip samples on the rising edge, data must hold through the high phase
  srInHeldA: assert property (@(posedge Clk_Out_2_All) disable iff (reset_i)
    srCk_o |=> (!srCk_o || $stable(srIn_o)))
    else $error("srIn_o changed while srCk_o high");

  // Done comes right after a high phase, never during it
  doneAfterHighA: assert property (@(posedge Clk_Out_2_All) disable iff (reset_i)
    cfgDone_o |-> (!srCk_o && $past(srCk_o)))
    else $error("cfgDone_o overlaps the shift clock");

endmodule

// File: src/readoutDeserializer.sv
// Readout deserializer packing inverted serial data into byte-swapped words
`timescale 1ns/1ps
`include "skirocCtrl_macros.svh"

module readoutDeserializer (
  input  logic                   Clk_Out_2_All,
  input  logic                   reset_i,
  input  logic                   doutb_i,
  input  logic                   transmitOn_i,
  output skirocCtrlPkg::roWord_t roWord_o,
  output logic                   roValid_o
);

  import skirocCtrlPkg::*;

  localparam int unsigned CNT_W  = $clog2(`WORD_W);
  localparam int unsigned HALF_W = `WORD_W / 2;    // One byte

  roWord_t          shiftReg;
  roWord_t          nextWord;
  logic [CNT_W-1:0] bitCnt;     // Wraps every word
  logic             wordEnd;

  // Chip drives its data active low
  assign nextWord = {shiftReg[`WORD_W-2:0], ~doutb_i};
  assign wordEnd  = transmitOn_i && (bitCnt == '1);   // 16th bit this cycle

  //////////////////////////////
  // Data path
  always_ff @(posedge Clk_Out_2_All)
  begin
    if (transmitOn_i)
    begin
      shiftReg <= nextWord;    // MSB first
    end
    if (wordEnd)
    begin
      roWord_o <= {nextWord[HALF_W-1:0], nextWord[`WORD_W-1:HALF_W]};   // Bytes swapped
    end
  end

  // Bit count and strobe
  always_ff @(posedge Clk_Out_2_All)
  begin
    if (reset_i)
    begin
      bitCnt    <= '0;
      roValid_o <= 1'b0;
    end
    else
    begin
      roValid_o <= wordEnd;
      if (transmitOn_i)
      begin
        bitCnt <= bitCnt + 1'b1;
      end
      else
      begin
        bitCnt <= '0;          // Partial word dropped
      end
    end
  end

endmodule

// File: src/skirocCtrlTop.sv
// Readout board control core top level with command, slow control and readout paths
`timescale 1ns/1ps

module skirocCtrlTop (
  input  logic                   Clk_Out_2_All,
  input  logic                   reset_i,
  // Host command strobe
  input  skirocCtrlPkg::cmdWord_t cmdData_i,
  input  logic                   cmdValid_i,
  // Chip readout
  input  logic                   doutb_i,
  input  logic                   transmitOn_i,
  // Chip slow control
  output logic                   srCk_o,
  output logic                   srIn_o,
  output logic                   srRstb_o,
  output logic                   select_o,
  output logic                   cfgDone_o,
  // Power pulsing
  output logic                   pwrOnD_o,
  output logic                   pwrOnA_o,
  output logic                   pwrOnAdc_o,
  output logic                   pwrOnDac_o,
  // Readout words to host
  output skirocCtrlPkg::roWord_t roWord_o,
  output logic                   roValid_o
);

  import skirocCtrlPkg::*;

  logic      rstInt;     // Stretched and synchronized reset
  scConfig_t scConfig;
  logic      startCfg;
  logic      powerOn;

  //////////////////////////////
  // Reset
  powerOnReset powerOnReset_i (
    .Clk_Out_2_All (Clk_Out_2_All),
    .reset_i       (reset_i),
    .rstInt_o      (rstInt)
  );

  // Commands in, strobe to start pulse in one cycle
  commandDecoder commandDecoder_i (
    .Clk_Out_2_All (Clk_Out_2_All),
    .reset_i       (rstInt),
    .cmdData_i     (cmdData_i),
    .cmdValid_i    (cmdValid_i),
    .config_o      (scConfig),
    .startCfg_o    (startCfg),
    .powerOn_o     (powerOn)
  );

  // Strobe, start pulse, first bit on the pin in the third cycle
  slowControlSerializer slowControlSerializer_i (
    .Clk_Out_2_All (Clk_Out_2_All),
    .reset_i       (rstInt),
    .config_i      (scConfig),
    .startCfg_i    (startCfg),
    .srCk_o        (srCk_o),
    .srIn_o        (srIn_o),
    .cfgDone_o     (cfgDone_o)
  );

  readoutDeserializer readoutDeserializer_i (
    .Clk_Out_2_All (Clk_Out_2_All),
    .reset_i       (rstInt),
    .doutb_i       (doutb_i),
    .transmitOn_i  (transmitOn_i),
    .roWord_o      (roWord_o),
    .roValid_o     (roValid_o)
  );

  //////////////////////////////
  // Pin drive
  assign srRstb_o   = 1'b1;                // Chip register never reset
  assign select_o   = scConfig.selectSc;   // Config or probe register
  assign pwrOnD_o   = powerOn;
  assign pwrOnA_o   = powerOn;
  assign pwrOnAdc_o = powerOn;
  assign pwrOnDac_o = 1'b1;                // DAC always on

endmodule

// File: verification/skirocCtrlTb.sv
// Testbench for skirocCtrlTop with clock, stimulus, reference model, compare tasks and timeout
`timescale 1ns/1ps
`include "skirocCtrl_macros.svh"

module skirocCtrlTb;

  import skirocCtrlPkg::*;

  // Both shift kinds plus readout bursts and reset and command overhead with margin
  localparam int TIMEOUT_CYCLES = 5 + `POR_CYCLES + 2 * `SC_BITS * 2 * `SR_HALF
                                  + `PROBE_BITS * 2 * `SR_HALF + 8 * `WORD_W + 300;

  logic Clk_Out_2_All;
  logic reset;
  cmdWord_t cmdData;
  logic cmdValid, doutb, transmitOn;
  logic srCk, srIn, srRstb, select, cfgDone;
  logic pwrOnD, pwrOnA, pwrOnAdc, pwrOnDac;
  roWord_t roWord;
  logic roValid;

  integer seed = 22;
  int errCnt = 0;
  int checkCnt = 0;
  int cycleCnt = 0;
  int doneCnt = 0;          // cfgDone pulses since last clear
  scConfig_t shadow = '0;   // Expected decoder state
  logic sampledBits[$];     // srIn at each rising srCk
  roWord_t roWords[$];
  roWord_t expWords[$];

  skirocCtrlTop skirocCtrlTop_i (
    .Clk_Out_2_All (Clk_Out_2_All),
    .reset_i       (reset),
    .cmdData_i     (cmdData),
    .cmdValid_i    (cmdValid),
    .doutb_i       (doutb),
    .transmitOn_i  (transmitOn),
    .srCk_o        (srCk),
    .srIn_o        (srIn),
    .srRstb_o      (srRstb),
    .select_o      (select),
    .cfgDone_o     (cfgDone),
    .pwrOnD_o      (pwrOnD),
    .pwrOnA_o      (pwrOnA),
    .pwrOnAdc_o    (pwrOnAdc),
    .pwrOnDac_o    (pwrOnDac),
    .roWord_o      (roWord),
    .roValid_o     (roValid)
  );

  initial
  begin
    Clk_Out_2_All = 1'b0;
    forever #50 Clk_Out_2_All = ~Clk_Out_2_All;   // 100 ns period
  end

  //////////////////////////////
  // Monitors
  always @(posedge srCk) sampledBits.push_back(srIn);   // Chip's own sampling edge

  always @(posedge Clk_Out_2_All)
  begin
    if (cfgDone) doneCnt++;
    if (roValid) roWords.push_back(roWord);
    cycleCnt++;
    if (cycleCnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, DUT stopped responding", cycleCnt);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  // Left aligned frame with the config MSB first or a one-hot probe
  function automatic logic [`PROBE_BITS-1:0] refFrame(input scConfig_t c);
    logic [`PROBE_BITS-1:0] f;
    f = '0;
    if (c.selectSc)
      f[`PROBE_BITS-1 -: `SC_BITS] = {c.gainDac, c.trigDac, c.feedbackCap, c.workMode,
                                       c.tdcOn, `CHIP_ID};
    else
      f[c.probeChan] = 1'b1;
    return f;
  endfunction

  // Serial bits in sending order with bit 15 first
  function automatic roWord_t refWord(input logic [`WORD_W-1:0] dout);
    roWord_t w;
    w = ~dout;                  // Active low data
    return {w[7:0], w[15:8]};
  endfunction

  // Order srCk cfgDone roValid srRstb select pwrOnD pwrOnA pwrOnAdc pwrOnDac
  function automatic logic [8:0] pinLevels();
    return {srCk, cfgDone, roValid, srRstb, select, pwrOnD, pwrOnA, pwrOnAdc, pwrOnDac};
  endfunction

  //////////////////////////////
  // Compare tasks
  task automatic checkLevels(input string name, input logic [8:0] exp, input logic [8:0] act);
    checkCnt++;
    if (act !== exp)
    begin
      errCnt++;
      $display("[ERROR] %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic checkWord(input string name, input roWord_t exp, input roWord_t act);
    checkCnt++;
    if (act !== exp)
    begin
      errCnt++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkFrame(input string name, input logic [`PROBE_BITS-1:0] exp, input int len);
    logic [`PROBE_BITS-1:0] got;
    got = '0;
    checkCnt++;
    if (sampledBits.size() != len)
    begin
      errCnt++;
      $display("%s: %0d bits shifted out, %0d expected", name, sampledBits.size(), len);
    end
    else
    begin
      foreach (sampledBits[i]) got[`PROBE_BITS-1-i] = sampledBits[i];   // Left aligned
      if (got !== exp)
      begin
        errCnt++;
        $display("[ERROR] %s expected %h actual %h", name, exp, got);
      end
    end
  endtask

  //////////////////////////////
  // Stimulus tasks called on a falling edge
  task automatic sendCmd(input opcode_t op, input logic [`PAY_W-1:0] pay);
    cmdData  = {op, pay};
    cmdValid = 1'b1;
    case (op)   // Shadow follows the command rules
      OP_GAIN_DAC: shadow.gainDac = pay[`DAC_W-1:0];
      OP_TRIG_DAC: shadow.trigDac = pay[`DAC_W-1:0];
      OP_ANALOG:   shadow[`CH_W+1 +: `CAP_W+2] = {pay[3:0], pay[4], pay[5]};
      OP_MODE:     shadow.selectSc = pay[0];
      OP_PROBE_CH: shadow.probeChan = pay[`CH_W-1:0];
      default:     ;
    endcase
    @(negedge Clk_Out_2_All);
    cmdValid = 1'b0;
  endtask

  // Optional gain change and second start while shifting
  task automatic shiftAndCheck(input string name, input bit disturb);
    logic [`PROBE_BITS-1:0] expBits;
    int expLen;
    expBits = refFrame(shadow);
    expLen  = shadow.selectSc ? `SC_BITS : `PROBE_BITS;
    sampledBits.delete();
    doneCnt = 0;
    sendCmd(OP_START_CFG, '0);
    if (disturb)
    begin
      repeat (20) @(negedge Clk_Out_2_All);
      sendCmd(OP_GAIN_DAC, `PAY_W'($random(seed)));
      sendCmd(OP_START_CFG, '0);
    end
    wait (doneCnt != 0);
    repeat (4) @(negedge Clk_Out_2_All);   // Room for a stray second pulse
    checkFrame(name, expBits, expLen);
    if (doneCnt != 1)
    begin
      errCnt++;
      $display("%s: cfgDone_o pulsed %0d times instead of once", name, doneCnt);
    end
  endtask

  // Full random words then a cut off tail
  task automatic streamBurst(input int nWords, input int cutBits);
    logic [`WORD_W-1:0] bits;
    transmitOn = 1'b1;
    for (int w = 0; w < nWords; w++)
    begin
      bits = `WORD_W'($random(seed));
      expWords.push_back(refWord(bits));
      for (int b = `WORD_W-1; b >= 0; b--)
      begin
        doutb = bits[b];
        @(negedge Clk_Out_2_All);
      end
    end
    bits = `WORD_W'($random(seed));
    for (int b = `WORD_W-1; b > `WORD_W-1-cutBits; b--)
    begin
      doutb = bits[b];
      @(negedge Clk_Out_2_All);
    end
    transmitOn = 1'b0;
    doutb      = 1'b1;   // Idle line
    @(negedge Clk_Out_2_All);
  endtask

  //////////////////////////////
  // Test sequence
  initial
  begin
    reset = 1'b1;
    cmdData = '0;
    cmdValid = 1'b0;
    doutb = 1'b1;
    transmitOn = 1'b0;
    repeat (5) @(negedge Clk_Out_2_All);
    reset = 1'b0;
    repeat (`POR_CYCLES) @(negedge Clk_Out_2_All);

    checkLevels("reset levels", 9'b000_1_0_000_1, pinLevels());

    for (int v = 1; v >= 0; v--)   // Levels up then down
    begin
      sendCmd(OP_POWER, `PAY_W'(v));
      sendCmd(OP_MODE, `PAY_W'(v));
      checkLevels("power and select", {3'b000, 1'b1, {4{v[0]}}, 1'b1}, pinLevels());
    end

    sendCmd(OP_MODE, `PAY_W'(1));
    sendCmd(OP_GAIN_DAC, `PAY_W'($random(seed)));
    sendCmd(OP_TRIG_DAC, `PAY_W'($random(seed)));
    sendCmd(OP_ANALOG, `PAY_W'($random(seed)));
    shiftAndCheck("config frame", 1'b0);

    sendCmd(OP_MODE, `PAY_W'(0));
    sendCmd(OP_PROBE_CH, `PAY_W'($random(seed)));
    shiftAndCheck("probe frame", 1'b0);

    sendCmd(OP_MODE, `PAY_W'(1));
    shiftAndCheck("config frame disturbed", 1'b1);

    streamBurst(4, 7);
    streamBurst(2, 0);
    repeat (4) @(negedge Clk_Out_2_All);
    if (roWords.size() != expWords.size())
    begin
      errCnt++;
      $display("Readout gave %0d words, %0d expected", roWords.size(), expWords.size());
    end
    else
      foreach (expWords[i]) checkWord("readout word", expWords[i], roWords[i]);

    $display("Checks run: %0d, errors: %0d", checkCnt, errCnt);
    if (errCnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: skirocCtrlTop.f
+incdir+src
src/skirocCtrlPkg.sv
src/powerOnReset.sv
src/commandDecoder.sv
src/slowControlSerializer.sv
src/readoutDeserializer.sv
src/skirocCtrlTop.sv
verification/skirocCtrlTb.sv

// File: Bender.yml
package:
  name: skirocCtrl

sources:
  - include_dirs:
      - src
    files:
      - src/skirocCtrlPkg.sv
      - src/powerOnReset.sv
      - src/commandDecoder.sv
      - src/slowControlSerializer.sv
      - src/readoutDeserializer.sv
      - src/skirocCtrlTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/skirocCtrlTb.sv
